/* axi_pkg.sv */
`default_nettype none

package axi_pkg;

    // read id, one per fill engine
    typedef logic [3:0] axi_id_t;

    localparam axi_id_t axi_id_icache = 4'd0;
    localparam axi_id_t axi_id_dcache = 4'd1;

    // fixed burst shape, the slave is expected to follow it
    localparam int axi_burst_beats = 8;   // arlen/awlen of 7

    localparam logic [1:0] axi_burst_incr = 2'b01;

    localparam logic [2:0] axi_size_word = 3'b010;  // 4 bytes per beat

endpackage

`default_nettype wire

/* cache_pkg.sv */
`default_nettype none

package cache_pkg;

    typedef logic [31:0]  addr_t;
    typedef logic [31:0]  word_t;
    typedef logic [255:0] line_t;  // word 0 in bits 31:0

    localparam int words_per_line   = 8;
    localparam int line_offset_bits = 5;

    typedef enum logic [1:0] {
        fill_idle,
        fill_request,   // waiting for the read address grant
        fill_collect
    } fill_state_e;

    typedef enum logic [1:0] {
        wb_idle,
        wb_addr,
        wb_data,
        wb_resp
    } wb_state_e;

endpackage

`default_nettype wire

/* line_fill.sv */
`timescale 1ns/100ps
`default_nettype none

module line_fill #(
    parameter axi_pkg::axi_id_t fill_id = axi_pkg::axi_id_icache
) (
    input  logic                aclk,
    input  logic                rst,
    input  logic                rd_req_i,
    input  cache_pkg::addr_t    rd_addr_i,
    input  logic                ar_grant_i,
    input  logic                beat_valid_i,
    input  cache_pkg::word_t    beat_data_i,
    input  logic                beat_last_i,
    output logic                ar_req_o,
    output cache_pkg::addr_t    ar_addr_o,
    output axi_pkg::axi_id_t    ar_id_o,
    output logic                ret_valid_o,
    output cache_pkg::line_t    ret_data_o
);

    cache_pkg::fill_state_e state;
    cache_pkg::line_t       line_q;  // beats so far, newest on top

    assign ar_req_o = (state == cache_pkg::fill_request);
    assign ar_id_o  = fill_id;

    always_ff @(posedge aclk) begin
        if (rst) begin
            state       <= cache_pkg::fill_idle;
            ret_valid_o <= 1'b0;
        end else begin
            ret_valid_o <= 1'b0;
            case (state)
                cache_pkg::fill_idle: begin
                    // req is still high during the return pulse
                    if (rd_req_i && !ret_valid_o) begin
                        state <= cache_pkg::fill_request;
                    end
                end
                cache_pkg::fill_request: begin
                    if (ar_grant_i) state <= cache_pkg::fill_collect;
                end
                cache_pkg::fill_collect: begin
                    if (beat_valid_i && beat_last_i) begin
                        state       <= cache_pkg::fill_idle;
                        ret_valid_o <= 1'b1;
                    end
                end
                default: state <= cache_pkg::fill_idle;
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (state == cache_pkg::fill_idle) begin
            ar_addr_o <= {rd_addr_i[31:cache_pkg::line_offset_bits],
                          {cache_pkg::line_offset_bits{1'b0}}};
        end
        if (state == cache_pkg::fill_collect && beat_valid_i) begin
            line_q <= {beat_data_i, line_q[$bits(cache_pkg::line_t)-1:$bits(cache_pkg::word_t)]};
            if (beat_last_i) begin
                ret_data_o <= {beat_data_i,
                               line_q[$bits(cache_pkg::line_t)-1:$bits(cache_pkg::word_t)]};
            end
        end
    end

endmodule

`default_nettype wire

/* read_arbiter.sv */
`timescale 1ns/100ps
`default_nettype none

module read_arbiter (
    input  logic                aclk,
    input  logic                rst,
    // instruction fill engine
    input  logic                i_req_i,
    input  cache_pkg::addr_t    i_addr_i,
    input  axi_pkg::axi_id_t    i_id_i,
    output logic                i_grant_o,
    output logic                i_beat_valid_o,
    // data fill engine
    input  logic                d_req_i,
    input  cache_pkg::addr_t    d_addr_i,
    input  axi_pkg::axi_id_t    d_id_i,
    output logic                d_grant_o,
    output logic                d_beat_valid_o,
    // shared beat toward both engines
    output cache_pkg::word_t    beat_data_o,
    output logic                beat_last_o,
    // axi read address
    output axi_pkg::axi_id_t    arid_o,
    output cache_pkg::addr_t    araddr_o,
    output logic                arvalid_o,
    input  logic                arready_i,
    // axi read data
    input  axi_pkg::axi_id_t    rid_i,
    input  cache_pkg::word_t    rdata_i,
    input  logic                rlast_i,
    input  logic                rvalid_i
);

    logic sel_d;    // pending address belongs to the data engine
    logic ar_done;

    assign ar_done = arvalid_o && arready_i;

    always_ff @(posedge aclk) begin
        if (rst) begin
            arvalid_o <= 1'b0;
            sel_d     <= 1'b0;
        end else if (ar_done) begin
            arvalid_o <= 1'b0;
        end else if (!arvalid_o && (d_req_i || i_req_i)) begin
            arvalid_o <= 1'b1;
            sel_d     <= d_req_i;  // data side wins a tie
        end
    end

    always_ff @(posedge aclk) begin
        if (!arvalid_o) begin
            araddr_o <= d_req_i ? d_addr_i : i_addr_i;
            arid_o   <= d_req_i ? d_id_i : i_id_i;
        end
    end

    assign d_grant_o = ar_done && sel_d;
    assign i_grant_o = ar_done && !sel_d;

    // beats go back by id, rready is tied high outside
    assign i_beat_valid_o = rvalid_i && (rid_i == i_id_i);
    assign d_beat_valid_o = rvalid_i && (rid_i == d_id_i);
    assign beat_data_o    = rdata_i;
    assign beat_last_o    = rlast_i;

endmodule

`default_nettype wire

/* line_writeback.sv */
`timescale 1ns/100ps
`default_nettype none

module line_writeback (
    input  logic                aclk,
    input  logic                rst,
    // cache side
    input  logic                wr_req_i,
    input  cache_pkg::addr_t    wr_addr_i,
    input  cache_pkg::line_t    wr_data_i,
    output logic                wr_rdy_o,
    output logic                wr_done_o,
    // axi write address
    output cache_pkg::addr_t    awaddr_o,
    output logic                awvalid_o,
    input  logic                awready_i,
    // axi write data
    output cache_pkg::word_t    wdata_o,
    output logic                wlast_o,
    output logic                wvalid_o,
    input  logic                wready_i,
    // axi write response
    input  logic                bvalid_i,
    output logic                bready_o
);

    cache_pkg::wb_state_e state;
    cache_pkg::line_t     line_q;
    logic [$clog2(cache_pkg::words_per_line)-1:0] beat_cnt;
    logic last_beat;

    assign last_beat = (int'(beat_cnt) == cache_pkg::words_per_line - 1);

    assign wr_rdy_o  = (state == cache_pkg::wb_idle);
    assign awvalid_o = (state == cache_pkg::wb_addr);
    assign wvalid_o  = (state == cache_pkg::wb_data);
    assign wlast_o   = wvalid_o && last_beat;
    assign bready_o  = (state == cache_pkg::wb_resp);
    assign wdata_o   = line_q[$bits(cache_pkg::word_t)-1:0];  // lowest word goes out first

    always_ff @(posedge aclk) begin
        if (rst) begin
            state     <= cache_pkg::wb_idle;
            beat_cnt  <= '0;
            wr_done_o <= 1'b0;
        end else begin
            wr_done_o <= 1'b0;
            case (state)
                cache_pkg::wb_idle: begin
                    if (wr_req_i) begin
                        state    <= cache_pkg::wb_addr;
                        beat_cnt <= '0;
                    end
                end
                cache_pkg::wb_addr: begin
                    if (awready_i) state <= cache_pkg::wb_data;
                end
                cache_pkg::wb_data: begin
                    if (wready_i) begin
                        beat_cnt <= beat_cnt + 1'b1;
                        if (last_beat) state <= cache_pkg::wb_resp;
                    end
                end
                cache_pkg::wb_resp: begin
                    if (bvalid_i) begin
                        state     <= cache_pkg::wb_idle;
                        wr_done_o <= 1'b1;
                    end
                end
                default: state <= cache_pkg::wb_idle;
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (state == cache_pkg::wb_idle && wr_req_i) begin
            awaddr_o <= {wr_addr_i[31:cache_pkg::line_offset_bits],
                         {cache_pkg::line_offset_bits{1'b0}}};
            line_q   <= wr_data_i;
        end else if (wvalid_o && wready_i) begin
            line_q <= line_q >> $bits(cache_pkg::word_t);
        end
    end

endmodule

`default_nettype wire

/* cache_axi_top.sv */
`timescale 1ns/100ps
`default_nettype none

module cache_axi_top (
    input  logic                aclk,
    input  logic                rst,
    // icache refill
    input  logic                icache_rd_req_i,
    input  cache_pkg::addr_t    icache_rd_addr_i,
    output logic                icache_ret_valid_o,
    output cache_pkg::line_t    icache_ret_data_o,
    // dcache refill
    input  logic                dcache_rd_req_i,
    input  cache_pkg::addr_t    dcache_rd_addr_i,
    output logic                dcache_ret_valid_o,
    output cache_pkg::line_t    dcache_ret_data_o,
    // dcache writeback
    input  logic                dcache_wr_req_i,
    input  cache_pkg::addr_t    dcache_wr_addr_i,
    input  cache_pkg::line_t    dcache_wr_data_i,
    output logic                dcache_wr_rdy_o,
    output logic                dcache_wr_done_o,
    // axi read
    output axi_pkg::axi_id_t    arid_o,
    output cache_pkg::addr_t    araddr_o,
    output logic                arvalid_o,
    input  logic                arready_i,
    input  axi_pkg::axi_id_t    rid_i,
    input  cache_pkg::word_t    rdata_i,
    input  logic                rlast_i,
    input  logic                rvalid_i,
    // axi write
    output cache_pkg::addr_t    awaddr_o,
    output logic                awvalid_o,
    input  logic                awready_i,
    output cache_pkg::word_t    wdata_o,
    output logic                wlast_o,
    output logic                wvalid_o,
    input  logic                wready_i,
    input  logic                bvalid_i,
    output logic                bready_o
);

    logic             i_req, d_req;
    cache_pkg::addr_t i_addr, d_addr;
    axi_pkg::axi_id_t i_id, d_id;
    logic             i_grant, d_grant;
    logic             i_beat_valid, d_beat_valid;
    cache_pkg::word_t beat_data;
    logic             beat_last;

    line_fill #(.fill_id(axi_pkg::axi_id_icache)) u_ifill (
        .aclk, .rst,
        .rd_req_i(icache_rd_req_i), .rd_addr_i(icache_rd_addr_i),
        .ar_grant_i(i_grant),
        .beat_valid_i(i_beat_valid), .beat_data_i(beat_data), .beat_last_i(beat_last),
        .ar_req_o(i_req), .ar_addr_o(i_addr), .ar_id_o(i_id),
        .ret_valid_o(icache_ret_valid_o), .ret_data_o(icache_ret_data_o)
    );

    line_fill #(.fill_id(axi_pkg::axi_id_dcache)) u_dfill (
        .aclk, .rst,
        .rd_req_i(dcache_rd_req_i), .rd_addr_i(dcache_rd_addr_i),
        .ar_grant_i(d_grant),
        .beat_valid_i(d_beat_valid), .beat_data_i(beat_data), .beat_last_i(beat_last),
        .ar_req_o(d_req), .ar_addr_o(d_addr), .ar_id_o(d_id),
        .ret_valid_o(dcache_ret_valid_o), .ret_data_o(dcache_ret_data_o)
    );

    read_arbiter u_rd_arb (
        .aclk, .rst,
        .i_req_i(i_req), .i_addr_i(i_addr), .i_id_i(i_id),
        .i_grant_o(i_grant), .i_beat_valid_o(i_beat_valid),
        .d_req_i(d_req), .d_addr_i(d_addr), .d_id_i(d_id),
        .d_grant_o(d_grant), .d_beat_valid_o(d_beat_valid),
        .beat_data_o(beat_data), .beat_last_o(beat_last),
        .arid_o, .araddr_o, .arvalid_o, .arready_i,
        .rid_i, .rdata_i, .rlast_i, .rvalid_i
    );

    line_writeback u_wb (
        .aclk, .rst,
        .wr_req_i(dcache_wr_req_i), .wr_addr_i(dcache_wr_addr_i),
        .wr_data_i(dcache_wr_data_i),
        .wr_rdy_o(dcache_wr_rdy_o), .wr_done_o(dcache_wr_done_o),
        .awaddr_o, .awvalid_o, .awready_i,
        .wdata_o, .wlast_o, .wvalid_o, .wready_i,
        .bvalid_i, .bready_o
    );

endmodule

`default_nettype wire

/* cache_axi_properties.sv */
`timescale 1ns/100ps
`default_nettype none

module cache_axi_properties (
    input logic        aclk,
    input logic        rst,
    input logic        arvalid_o,
    input logic [31:0] araddr_o,
    input logic        arready_i,
    input logic        wvalid_o,
    input logic [31:0] wdata_o,
    input logic        wlast_o,
    input logic        wready_i,
    input logic        icache_ret_valid_o,
    input logic        dcache_ret_valid_o
);

    ar_stable: assert property (@(posedge aclk) disable iff (rst)
        arvalid_o && !arready_i |=> arvalid_o && $stable(araddr_o))
        else $error("read address changed before arready");

    w_stable: assert property (@(posedge aclk) disable iff (rst)
        wvalid_o && !wready_i |=> wvalid_o && $stable(wdata_o))
        else $error("write data changed before wready");

    wlast_in_beat: assert property (@(posedge aclk) disable iff (rst)
        wlast_o |-> wvalid_o)
        else $error("wlast without wvalid");

    iret_pulse: assert property (@(posedge aclk) disable iff (rst)
        icache_ret_valid_o |=> !icache_ret_valid_o)
        else $error("icache return longer than one cycle");

    dret_pulse: assert property (@(posedge aclk) disable iff (rst)
        dcache_ret_valid_o |=> !dcache_ret_valid_o)
        else $error("dcache return longer than one cycle");

endmodule

bind cache_axi_top cache_axi_properties u_props (.*);

`default_nettype wire

/* tb_cache_axi.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_cache_axi;

    localparam int k_ifill = 0;
    localparam int k_dfill = 1;
    localparam int k_both  = 2;
    localparam int k_wb    = 3;
    localparam int n_ops   = 9;
    localparam int max_wait = 3000;

    logic aclk = 1'b0;
    logic rst  = 1'b1;
    logic i_req = 1'b0, d_req = 1'b0, wr_req = 1'b0;
    logic [31:0] i_addr = '0, d_addr = '0, wr_addr = '0;
    logic [255:0] wr_data = '0;
    logic arready = 1'b0, awready = 1'b0, wready = 1'b0, bvalid = 1'b0;
    logic [3:0] rid = '0;
    logic [31:0] rdata = '0;
    logic rlast = 1'b0, rvalid = 1'b0;
    logic i_ret, d_ret, wr_rdy, wr_done, arvalid_o, awvalid_o, wvalid_o, wlast_o, bready_o;
    logic [255:0] i_line, d_line;
    logic [31:0] araddr_o, awaddr_o, wdata_o;
    logic [3:0] arid_o;

    integer seed = 32'h3d11_0326;
    int err_cnt = 0;
    int chk_cnt = 0;

    logic [31:0] mem [logic [31:0]];  // written words only
    logic [31:0] rq_addr[$];
    logic [3:0]  rq_id[$];
    int          rq_beat = 0;
    logic [3:0]  ar_ids[$];
    logic [31:0] ar_addrs[$];
    logic [31:0] aw_base = '0;
    int          w_cnt = 0;
    logic [255:0] exp_wline = '0;

    // operation table
    int          op_kind [n_ops] = '{k_ifill, k_dfill, k_both, k_wb, k_dfill,
                                     k_both, k_wb, k_both, k_ifill};
    logic [31:0] op_addr [n_ops] = '{32'h0000_1004, 32'h0000_2013, 32'h0000_3008,
                                     32'h0000_2000, 32'h0000_201c, 32'h0000_4444,
                                     32'h0000_5010, 32'h0000_5000, 32'h0000_2004};

    cache_axi_top dut0 (
        .aclk, .rst,
        .icache_rd_req_i(i_req), .icache_rd_addr_i(i_addr),
        .icache_ret_valid_o(i_ret), .icache_ret_data_o(i_line),
        .dcache_rd_req_i(d_req), .dcache_rd_addr_i(d_addr),
        .dcache_ret_valid_o(d_ret), .dcache_ret_data_o(d_line),
        .dcache_wr_req_i(wr_req), .dcache_wr_addr_i(wr_addr), .dcache_wr_data_i(wr_data),
        .dcache_wr_rdy_o(wr_rdy), .dcache_wr_done_o(wr_done),
        .arid_o, .araddr_o, .arvalid_o, .arready_i(arready),
        .rid_i(rid), .rdata_i(rdata), .rlast_i(rlast), .rvalid_i(rvalid),
        .awaddr_o, .awvalid_o, .awready_i(awready),
        .wdata_o, .wlast_o, .wvalid_o, .wready_i(wready),
        .bvalid_i(bvalid), .bready_o
    );

    always #50 aclk = ~aclk;

    function automatic logic [31:0] mem_rd(input logic [31:0] a);
        if (mem.exists(a)) return mem[a];
        return a ^ 32'h5a5a_0000;
    endfunction

    // slave side address of one beat
    function automatic logic [31:0] beat_addr(input logic [31:0] base, input logic [1:0] burst,
                                              input int beat);
        if (burst == axi_pkg::axi_burst_incr) return base + (32'(beat) << axi_pkg::axi_size_word);
        return base;  // fixed burst
    endfunction

    function automatic logic [255:0] expect_line(input logic [31:0] a);
        logic [255:0] l;
        for (int k = 0; k < 8; k++) l[k*32 +: 32] = mem_rd({a[31:5], 5'd0} + 32'(4 * k));
        return l;
    endfunction

    function automatic logic [255:0] make_wb_line(input int idx);
        logic [255:0] l;
        for (int k = 0; k < 8; k++) l[k*32 +: 32] = 32'hd00d_0000 ^ 32'(idx << 8) ^ 32'(k);
        return l;
    endfunction

    task automatic check_val(input string name, input logic [255:0] exp, input logic [255:0] got);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("** Error t=%0t %s exp=%h got=%h", $time, name, exp, got);
        end
    endtask

    // AXI slave with registered outputs
    always @(posedge aclk) begin
        if (!rst) begin
            if (arvalid_o && arready) begin
                ar_ids.push_back(arid_o);
                ar_addrs.push_back(araddr_o);
                rq_addr.push_back(araddr_o);
                rq_id.push_back(arid_o);
            end
            if (rvalid) begin  // rready is always high
                rq_beat++;
                if (rq_beat == axi_pkg::axi_burst_beats) begin
                    rq_beat = 0;
                    void'(rq_addr.pop_front());
                    void'(rq_id.pop_front());
                end
            end
            if (rq_addr.size() > 0 && ($random(seed) & 3) != 0) begin
                rvalid <= 1'b1;
                rid    <= rq_id[0];
                rdata  <= mem_rd(beat_addr(rq_addr[0], axi_pkg::axi_burst_incr, rq_beat));
                rlast  <= (rq_beat == axi_pkg::axi_burst_beats - 1);
            end else begin
                rvalid <= 1'b0;
                rlast  <= 1'b0;
            end
            arready <= (rq_addr.size() < 2) && ($random(seed) & 1);
            if (awvalid_o && awready) begin
                aw_base = awaddr_o;
                w_cnt   = 0;
            end
            if (wvalid_o && wready) begin
                check_val("wdata_o", exp_wline[w_cnt*32 +: 32], wdata_o);
                check_val("wlast_o", (w_cnt == 7), wlast_o);
                mem[beat_addr(aw_base, axi_pkg::axi_burst_incr, w_cnt)] = wdata_o;
                if (w_cnt == axi_pkg::axi_burst_beats - 1) bvalid <= 1'b1;
                w_cnt++;
            end
            if (bvalid && bready_o) bvalid <= 1'b0;
            awready <= $random(seed) & 1;
            wready  <= ($random(seed) & 3) != 0;
        end
    end

    task automatic run_fill(input int kind, input logic [31:0] a);
        logic i_done;
        logic d_done;
        int n;
        i_done = (kind == k_dfill);
        d_done = (kind == k_ifill);
        n = 0;
        ar_ids.delete();
        ar_addrs.delete();
        @(posedge aclk);
        i_req  <= !i_done;
        i_addr <= a;
        d_req  <= !d_done;
        d_addr <= a + 32'h40;  // data side on the next lines
        while (!(i_done && d_done) && n < max_wait) begin
            @(posedge aclk);
            n++;
            if (i_ret) begin
                i_req  <= 1'b0;
                i_done = 1'b1;
                check_val("icache_ret_data_o", expect_line(a), i_line);
            end
            if (d_ret) begin
                d_req  <= 1'b0;
                d_done = 1'b1;
                check_val("dcache_ret_data_o", expect_line(a + 32'h40), d_line);
            end
        end
        if (n >= max_wait) begin
            err_cnt++;
            $display("timeout waiting for a line fill at %h", a);
        end else begin
            check_val("arid_o", (kind == k_ifill) ? 4'd0 : 4'd1, ar_ids[0]);
            check_val("araddr_o", (kind == k_ifill) ? {a[31:5], 5'd0}
                      : {a[31:5], 5'd0} + 32'h40, ar_addrs[0]);
        end
    endtask

    task automatic run_writeback(input int idx, input logic [31:0] a);
        int n;
        n = 0;
        while (!wr_rdy && n < max_wait) begin
            @(posedge aclk);
            n++;
        end
        exp_wline = make_wb_line(idx);
        @(posedge aclk);
        wr_req  <= 1'b1;
        wr_addr <= a + 32'h40;  // so the following data fill hits this line
        wr_data <= exp_wline;
        @(posedge aclk);
        wr_req <= 1'b0;
        while (!wr_done && n < max_wait) begin
            @(posedge aclk);
            n++;
            if (awvalid_o) check_val("awaddr_o", {a[31:5], 5'd0} + 32'h40, awaddr_o);
        end
        if (n >= max_wait) begin
            err_cnt++;
            $display("timeout waiting for writeback done at %h", a);
        end
    endtask

    initial begin
        repeat (3) @(posedge aclk);
        rst <= 1'b0;
        @(posedge aclk);
        check_val("arvalid_o", 0, arvalid_o);
        check_val("awvalid_o", 0, awvalid_o);
        check_val("wvalid_o", 0, wvalid_o);
        check_val("wlast_o", 0, wlast_o);
        check_val("bready_o", 0, bready_o);
        check_val("icache_ret_valid_o", 0, i_ret);
        check_val("dcache_ret_valid_o", 0, d_ret);
        check_val("dcache_wr_done_o", 0, wr_done);
        check_val("dcache_wr_rdy_o", 1, wr_rdy);
        for (int i = 0; i < n_ops; i++) begin
            if (op_kind[i] == k_wb) run_writeback(i, op_addr[i]);
            else run_fill(op_kind[i], op_addr[i]);
        end
        repeat (4) @(posedge aclk);
        $display("errors: %0d  checks: %0d", err_cnt, chk_cnt);
        if (err_cnt == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
axi_pkg.sv
cache_pkg.sv
line_fill.sv
read_arbiter.sv
line_writeback.sv
cache_axi_top.sv
cache_axi_properties.sv
tb_cache_axi.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f compile.f --top-module tb_cache_axi -o sim_tb
	./obj_dir/sim_tb | tee /dev/stderr | grep -q "ALL CHECKS PASSED"

clean:
	rm -rf obj_dir
